//--- rtl/io_consts.svh
/* I/O unit constants */

`ifndef IO_CONSTS_SVH
`define IO_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execution phase timer (XPT)
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define IO_XPT_FIRST  3 // Address phase.
`define IO_XPT_BUS    4 // Strobe phase.
`define IO_XPT_SAMPLE 5 // Read data phase.
`define IO_XPT_LAST   6 // End group.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control word queue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define IO_FIFO_DEPTH 4

`endif

//--- rtl/io_pkg.sv
/* I/O unit types */

package io_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // IN A,(n) when is_out is low, OUT (n),A when high.
    typedef struct packed {
        logic       is_out;  // ITABLE bit 0.
        logic [7:0] port;    // Operand n.
        logic [7:0] a_value; // Accumulator.
    } io_instr_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Phase control word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [2:0] xpt_t;

    typedef struct packed {
        xpt_t       phase;
        logic       is_out;
        logic       sel_addr_aop; // Address from operand.
        logic       sel_data_a;   // Data from A.
        logic       write_a;      // Accumulator writeback.
        logic       last;         // Phase 6.
        logic [7:0] port;
        logic [7:0] data;
    } io_ctrl_t;

endpackage

//--- rtl/io_phase_decoder.sv
/* XPT and ITABLE phase decoder */
`timescale 1ns/1ps

module io_phase_decoder
    import io_pkg::*;
(
    input  logic     enable,
    input  xpt_t     xpt,
    input  logic     is_out,
    output io_ctrl_t ctrl
);

    logic       t0xx;
    logic       t1xx;
    logic [3:0] ph;   // One-hot with bit k for phase k+3.
    logic [3:0] pc_i; // Per-phase IN selects.
    logic [3:0] pc_o; // Per-phase OUT selects.
    logic       sel_3_6;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // XPT
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Split on bit 2 first.
    assign t0xx = enable & ~xpt[2];
    assign t1xx = enable & xpt[2];

    assign ph[0] = t0xx & xpt[1] & xpt[0];   // 011.
    assign ph[1] = t1xx & ~xpt[1] & ~xpt[0]; // 100.
    assign ph[2] = t1xx & ~xpt[1] & xpt[0];  // 101.
    assign ph[3] = t1xx & xpt[1];            // 11x as 7 never occurs.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Direction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign pc_i = ph & {4{~is_out}};
    assign pc_o = ph & {4{is_out}};

    // Any of 3 to 6.
    assign sel_3_6 = |(pc_i | pc_o);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        ctrl              = '0;
        ctrl.phase        = enable ? xpt : '0;
        ctrl.is_out       = is_out & enable;
        ctrl.sel_addr_aop = sel_3_6;
        ctrl.sel_data_a   = |pc_o;              // OUT only.
        ctrl.write_a      = pc_i[3];            // IN at phase 6.
        ctrl.last         = pc_i[3] | pc_o[3];
    end

endmodule

//--- rtl/io_sequencer.sv
/* I/O instruction sequencer */
`timescale 1ns/1ps
`include "io_consts.svh"

module io_sequencer
    import io_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      instr_valid,
    input  io_instr_t instr,
    input  logic      full,
    output logic      busy,
    output logic      push,
    output io_ctrl_t  push_data
);

    io_instr_t instr_q;
    xpt_t      xpt;
    io_ctrl_t  dec_ctrl;
    logic      accept;

    assign accept = instr_valid & ~busy;
    assign push   = busy & ~full; // XPT holds while full.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // XPT
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            xpt  <= '0;
        end else if (accept) begin
            busy <= 1'b1;
            xpt  <= xpt_t'(`IO_XPT_FIRST);
        end else if (push) begin
            if (xpt == xpt_t'(`IO_XPT_LAST)) begin
                busy <= 1'b0;                   // Ends after the last push.
                xpt  <= '0;
            end else begin
                xpt <= xpt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            instr_q <= instr;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode and merge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    io_phase_decoder u_decoder (
        .enable (busy),
        .xpt    (xpt),
        .is_out (instr_q.is_out),
        .ctrl   (dec_ctrl)
    );

    always_comb begin
        push_data      = dec_ctrl;
        push_data.port = instr_q.port;
        push_data.data = instr_q.a_value;
    end

endmodule

//--- rtl/ctrl_fifo.sv
/* Control word FIFO */
`timescale 1ns/1ps

module ctrl_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic arst_n,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     pop_data,
    output logic full,
    output logic empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    assign full  = (count == CW'(DEPTH));
    assign empty = (count == '0);

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    assign pop_data = mem[rd_ptr];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pointers and occupancy
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither.
            endcase
        end
    end

    // Storage.
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

//--- rtl/io_bus_executor.sv
/* I/O bus executor */
`timescale 1ns/1ps
`include "io_consts.svh"

module io_bus_executor
    import io_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  io_ctrl_t   pop_data,
    input  logic       empty,
    output logic       pop,
    input  logic [7:0] io_rdata,
    input  logic       io_wait,
    output logic [7:0] io_addr,
    output logic [7:0] io_wdata,
    output logic       io_rd,
    output logic       io_wr,
    output logic       acc_we,
    output logic [7:0] acc_wdata,
    output logic       done
);

    logic       rd_phase;  // IN word of phase 5 at the head.
    logic       bus_pop;
    logic       rd_pop;
    logic [7:0] rd_q;

    assign rd_phase = ~empty & ~pop_data.is_out &
                      (pop_data.phase == xpt_t'(`IO_XPT_SAMPLE));

    // Stall only while the device stretches a read.
    assign pop = ~empty & ~(rd_phase & io_wait);

    assign bus_pop = pop & (pop_data.phase == xpt_t'(`IO_XPT_BUS));
    assign rd_pop  = pop & rd_phase;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Strobes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            io_wr  <= 1'b0;
            io_rd  <= 1'b0;
            done   <= 1'b0;
            acc_we <= 1'b0;
        end else begin
            io_wr  <= bus_pop & pop_data.is_out;
            io_rd  <= bus_pop & ~pop_data.is_out;
            done   <= pop & pop_data.last;
            acc_we <= pop & pop_data.last & pop_data.write_a; // IN only.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address and data
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (bus_pop) begin
            io_addr  <= pop_data.sel_addr_aop ? pop_data.port : '0;
            io_wdata <= pop_data.sel_data_a ? pop_data.data : '0;
        end
        if (rd_pop) begin
            rd_q <= io_rdata;                   // First cycle without wait.
        end
        if (pop & pop_data.write_a) begin
            acc_wdata <= rd_q;
        end
    end

endmodule

//--- rtl/io_unit_top.sv
/* I/O instruction unit */
`timescale 1ns/1ps
`include "io_consts.svh"

module io_unit_top
    import io_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       instr_valid,
    input  io_instr_t  instr,
    input  logic [7:0] io_rdata,
    input  logic       io_wait,
    output logic       busy,
    output logic [7:0] io_addr,
    output logic [7:0] io_wdata,
    output logic       io_rd,
    output logic       io_wr,
    output logic       acc_we,
    output logic [7:0] acc_wdata,
    output logic       done
);

    logic     push;
    io_ctrl_t push_data;
    logic     full;
    logic     pop;
    io_ctrl_t pop_data;
    logic     empty;

    io_sequencer u_sequencer (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .full        (full),
        .busy        (busy),
        .push        (push),
        .push_data   (push_data)
    );

    ctrl_fifo #(
        .T     (io_ctrl_t),
        .DEPTH (`IO_FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .full      (full),
        .empty     (empty)
    );

    io_bus_executor u_executor (
        .clk       (clk),
        .arst_n    (arst_n),
        .pop_data  (pop_data),
        .empty     (empty),
        .pop       (pop),
        .io_rdata  (io_rdata),
        .io_wait   (io_wait),
        .io_addr   (io_addr),
        .io_wdata  (io_wdata),
        .io_rd     (io_rd),
        .io_wr     (io_wr),
        .acc_we    (acc_we),
        .acc_wdata (acc_wdata),
        .done      (done)
    );

endmodule

//--- dv/io_unit_props.sv
/* I/O unit bus properties */
`timescale 1ns/1ps

module io_unit_props (
    input logic clk,
    input logic arst_n,
    input logic busy,
    input logic io_rd,
    input logic io_wr,
    input logic acc_we,
    input logic done
);

    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (!arst_n) !(io_rd && io_wr)
    ) else $error("io_rd and io_wr high in the same cycle");

    a_done_pulse: assert property (
        @(posedge clk) disable iff (!arst_n) done |=> !done
    ) else $error("done held high for more than one cycle");

    a_acc_we_pulse: assert property (
        @(posedge clk) disable iff (!arst_n) acc_we |=> !acc_we
    ) else $error("acc_we held high for more than one cycle");

    a_acc_we_done: assert property (
        @(posedge clk) disable iff (!arst_n) acc_we |-> done
    ) else $error("acc_we without done");

    // Busy low throughout reset.
    a_busy_reset: assert property (
        @(posedge clk) !arst_n |-> !busy
    ) else $error("busy high during reset");

endmodule

bind io_unit_top io_unit_props u_props (
    .clk    (clk),
    .arst_n (arst_n),
    .busy   (busy),
    .io_rd  (io_rd),
    .io_wr  (io_wr),
    .acc_we (acc_we),
    .done   (done)
);

//--- dv/io_unit_tb.sv
/* I/O unit testbench */
`timescale 1ns/1ps

module io_unit_tb
    import io_pkg::*;
();

    localparam int NUM_ROWS     = 12;
    localparam int BUSY_TIMEOUT = 100;
    localparam int DONE_TIMEOUT = 200;

    typedef struct packed {
        logic       is_out;
        logic [7:0] port;
        logic [7:0] a_value;
        logic [7:0] rd_byte;   // Device byte for IN.
        logic [7:0] wait_len;  // Base io_wait length.
        logic       long_busy; // Busy past four cycles.
    } row_t;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       instr_valid;
    io_instr_t  instr;
    logic [7:0] io_rdata;
    logic       io_wait;
    logic       busy;
    logic [7:0] io_addr;
    logic [7:0] io_wdata;
    logic       io_rd;
    logic       io_wr;
    logic       acc_we;
    logic [7:0] acc_wdata;
    logic       done;

    row_t rows [NUM_ROWS];
    int   bus_idx;
    int   done_idx;
    int   wait_left;

    always #20 clk = ~clk;

    io_unit_top UUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .io_rdata    (io_rdata),
        .io_wait     (io_wait),
        .busy        (busy),
        .io_addr     (io_addr),
        .io_wdata    (io_wdata),
        .io_rd       (io_rd),
        .io_wr       (io_wr),
        .acc_we      (acc_we),
        .acc_wdata   (acc_wdata),
        .done        (done)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Failure handling and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic stop_on_failure();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("ERROR: %s", what);
        stop_on_failure();
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_idle_outputs(input string when);
        check_value({when, " busy"}, 0, int'(busy));
        check_value({when, " io_rd"}, 0, int'(io_rd));
        check_value({when, " io_wr"}, 0, int'(io_wr));
        check_value({when, " acc_we"}, 0, int'(acc_we));
        check_value({when, " done"}, 0, int'(done));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Columns are is_out, port, A, device byte, wait and busy stretched.
    task automatic load_table();
        rows[0]  = '{1'b1, 8'h10, 8'h5A, 8'h00, 8'd0,  1'b0};
        rows[1]  = '{1'b0, 8'h21, 8'h00, 8'hC3, 8'd0,  1'b0};
        rows[2]  = '{1'b1, 8'h7F, 8'hA5, 8'h00, 8'd0,  1'b0};
        rows[3]  = '{1'b0, 8'h80, 8'h00, 8'h3C, 8'd0,  1'b0};
        rows[4]  = '{1'b0, 8'h42, 8'h00, 8'h99, 8'd8,  1'b0};
        rows[5]  = '{1'b1, 8'h43, 8'h01, 8'h00, 8'd0,  1'b1}; // After a long read.
        rows[6]  = '{1'b0, 8'h55, 8'h00, 8'hE7, 8'd10, 1'b0};
        rows[7]  = '{1'b0, 8'h56, 8'h00, 8'h18, 8'd6,  1'b1};
        rows[8]  = '{1'b1, 8'h57, 8'hFF, 8'h00, 8'd0,  1'b1};
        rows[9]  = '{1'b0, 8'hFE, 8'h00, 8'h6D, 8'd0,  1'b0};
        rows[10] = '{1'b1, 8'h00, 8'h81, 8'h00, 8'd0,  1'b0};
        rows[11] = '{1'b0, 8'h01, 8'h00, 8'h7E, 8'd0,  1'b0};
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Device model and monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic observe_done();
        if (acc_we && !done) begin
            report_error("acc_we pulsed without done");
        end
        if (done) begin
            if (done_idx >= NUM_ROWS) begin
                report_error("done pulsed with no instruction outstanding");
            end
            check_value($sformatf("row %0d done order", done_idx), done_idx + 1, bus_idx);
            check_value($sformatf("row %0d acc_we", done_idx),
                        int'(!rows[done_idx].is_out), int'(acc_we));
            if (acc_we) begin
                check_value($sformatf("row %0d acc_wdata", done_idx),
                            int'(rows[done_idx].rd_byte), int'(acc_wdata));
            end
            done_idx++;
        end
    endtask

    task automatic observe_bus();
        if (io_rd && io_wr) begin
            report_error("io_rd and io_wr high together");
        end
        if (io_rd || io_wr) begin
            if (bus_idx >= NUM_ROWS) begin
                report_error("bus strobe with no instruction outstanding");
            end
            check_value($sformatf("row %0d io_wr", bus_idx),
                        int'(rows[bus_idx].is_out), int'(io_wr));
            check_value($sformatf("row %0d io_addr", bus_idx),
                        int'(rows[bus_idx].port), int'(io_addr));
            if (io_wr) begin
                check_value($sformatf("row %0d io_wdata", bus_idx),
                            int'(rows[bus_idx].a_value), int'(io_wdata));
            end else begin
                io_rdata  = rows[bus_idx].rd_byte;
                wait_left = int'(rows[bus_idx].wait_len) + int'($urandom_range(3, 0));
            end
            bus_idx++;
        end
    endtask

    initial begin : device_model
        void'($urandom(50818));
        io_wait   = 1'b0;
        io_rdata  = 8'h00;
        wait_left = 0;
        bus_idx   = 0;
        done_idx  = 0;
        forever begin
            @(negedge clk);
            if (arst_n) begin
                observe_done();
                observe_bus();
            end
            io_wait = (wait_left > 0); // Stretch the read.
            if (wait_left > 0) begin
                wait_left--;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : run
        int busy_cycles;
        int wait_cycles;

        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        load_table();

        repeat (5) begin
            @(negedge clk);
            check_idle_outputs("reset");
        end
        arst_n = 1'b1;
        @(negedge clk);
        check_idle_outputs("after reset");

        // Each row goes in as soon as busy is low.
        for (int i = 0; i < NUM_ROWS; i++) begin
            instr_valid    = 1'b1;
            instr.is_out   = rows[i].is_out;
            instr.port     = rows[i].port;
            instr.a_value  = rows[i].a_value;
            @(negedge clk);
            instr_valid = 1'b0;
            check_value($sformatf("row %0d accepted", i), 1, int'(busy));
            busy_cycles = 0;
            while (busy) begin
                if (busy_cycles >= BUSY_TIMEOUT) begin
                    report_error($sformatf("row %0d: timeout waiting for busy to fall", i));
                end
                busy_cycles++;
                @(negedge clk);
            end
            if (rows[i].long_busy) begin
                check_value($sformatf("row %0d busy stretched", i), 1,
                            int'(busy_cycles > 4));
            end else begin
                check_value($sformatf("row %0d busy at least 4", i), 1,
                            int'(busy_cycles >= 4));
            end
        end

        wait_cycles = 0;
        while (done_idx < NUM_ROWS) begin
            if (wait_cycles >= DONE_TIMEOUT) begin
                report_error("timeout waiting for the last done");
            end
            wait_cycles++;
            @(negedge clk);
        end

        repeat (10) @(negedge clk); // Bus stays quiet.
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+rtl
rtl/io_pkg.sv
rtl/io_phase_decoder.sv
rtl/io_sequencer.sv
rtl/ctrl_fifo.sv
rtl/io_bus_executor.sv
rtl/io_unit_top.sv
dv/io_unit_props.sv
dv/io_unit_tb.sv

//--- Makefile
# Verilator flow for the I/O instruction unit.

TOP := io_unit_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f filelist.f

# A $fatal in the testbench gives a non-zero exit status.
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
